// File: source/videoPkg.sv
/* Types, raster defaults and fixed TMDS code words shared by the video transmitter.
   Modules pull these in with a wildcard import in their header. */
package videoPkg;

	////////////////////////////////////////////////////////////
	// Vector types

	typedef logic [9:0] tmdsSymbol;
	typedef logic [7:0] colorComponent;
	// Control bits of one channel, C1 in bit 1 and C0 in bit 0
	typedef logic [1:0] controlPair;
	typedef logic [9:0] pixelCount;
	// Running DC bias in units of two bits
	typedef logic signed [3:0] disparityCount;

	// Horizontal position within a line
	typedef enum logic [1:0] {
		activeVideo,
		blanking,
		videoPreamble,
		videoGuard
	} lineRegion;

	////////////////////////////////////////////////////////////
	// Link constants

	localparam int channelCount = 3;
	localparam int preambleLength = 8;
	localparam int guardLength = 2;

	// 720x480p raster
	localparam int defaultWidth = 720;
	localparam int defaultHeight = 480;
	localparam int defaultTotalWidth = 858;
	localparam int defaultTotalHeight = 525;
	localparam int defaultHFrontPorch = 16;
	localparam int defaultHSyncLength = 62;
	localparam int defaultVFrontPorch = 9;
	localparam int defaultVSyncLength = 6;

	////////////////////////////////////////////////////////////
	// Fixed code words

	localparam tmdsSymbol guardSymbolOuter = 10'b1011001100;
	localparam tmdsSymbol guardSymbolInner = 10'b0100110011;

	// DVI control words, indexed by {C1, C0}
	localparam tmdsSymbol controlSymbols [4] = '{
		10'b1101010100,
		10'b0010101011,
		10'b0101010100,
		10'b1010101011
	};

endpackage

// File: source/videoTimingIf.sv
`timescale 1ns/1ns
/* Raster flags from the timing generator to the channel encoders and the output stage */
interface videoTimingIf;

	logic drawArea;
	// Both syncs are active low
	logic hSync;
	logic vSync;
	// Bit 0 is CTL0, bit 3 is CTL3
	logic [3:0] preamble;
	logic videoGuard;

	modport source (
		output drawArea, hSync, vSync, preamble, videoGuard
	);

	modport encoder (
		input drawArea, hSync, vSync, preamble
	);

	modport link (
		input videoGuard
	);

endinterface

// File: source/videoTiming.sv
`timescale 1ns/1ns
/* Raster counters and registered sync, draw, preamble and guard flags.
   The raster is set by the timing parameters from the top level. */
module videoTiming import videoPkg::*; #(
	parameter int displayWidth = defaultWidth,
	parameter int displayHeight = defaultHeight,
	parameter int totalWidth = defaultTotalWidth,
	parameter int totalHeight = defaultTotalHeight,
	parameter int hFrontPorch = defaultHFrontPorch,
	parameter int hSyncLength = defaultHSyncLength,
	parameter int vFrontPorch = defaultVFrontPorch,
	parameter int vSyncLength = defaultVSyncLength
) (
	input logic pixclk,
	input logic reset,
	videoTimingIf.source timing
);

	// Last x of each horizontal region
	localparam pixelCount lastActiveX = pixelCount'(displayWidth - 1);
	localparam pixelCount lastBlankX = pixelCount'(totalWidth - guardLength - preambleLength - 1);
	localparam pixelCount lastPreambleX = pixelCount'(totalWidth - guardLength - 1);
	localparam pixelCount lastX = pixelCount'(totalWidth - 1);
	localparam pixelCount lastY = pixelCount'(totalHeight - 1);

	localparam pixelCount activeLines = pixelCount'(displayHeight);
	localparam pixelCount hSyncStart = pixelCount'(displayWidth + hFrontPorch);
	localparam pixelCount hSyncEnd = pixelCount'(displayWidth + hFrontPorch + hSyncLength);
	localparam pixelCount vSyncFirstLine = pixelCount'(displayHeight + vFrontPorch - 1);
	localparam pixelCount vSyncLastLine = pixelCount'(displayHeight + vFrontPorch + vSyncLength - 1);

	pixelCount x;
	pixelCount y;
	lineRegion region;
	logic inHSync;
	logic inVSync;

	////////////////////////////////////////////////////////////
	// Raster counters

	always_ff @(posedge pixclk) begin
		if (reset) begin
			x <= '0;
			y <= '0;
		end else if (x == lastX) begin
			x <= '0;
			y <= (y == lastY) ? '0 : y + 1'b1;
		end else begin
			x <= x + 1'b1;
		end
	end

	// Region follows x, so it moves on the edge that leaves each region
	always_ff @(posedge pixclk) begin
		if (reset) begin
			region <= activeVideo;
		end else begin
			case (region)
				activeVideo: if (x == lastActiveX) region <= blanking;
				blanking: if (x == lastBlankX) region <= videoPreamble;
				videoPreamble: if (x == lastPreambleX) region <= videoGuard;
				videoGuard: if (x == lastX) region <= activeVideo;
				default: region <= activeVideo;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Flags

	// Vertical sync starts and ends at the hsync edge so both move together
	always_comb begin
		inHSync = (x >= hSyncStart) && (x < hSyncEnd);
		inVSync = ((y == vSyncFirstLine && x >= hSyncStart) || y > vSyncFirstLine)
			&& ((y == vSyncLastLine && x < hSyncStart) || y < vSyncLastLine);
	end

	always_ff @(posedge pixclk) begin
		if (reset) begin
			timing.drawArea <= 1'b0;
			timing.hSync <= 1'b1;
			timing.vSync <= 1'b1;
			timing.preamble <= 4'b0000;
			timing.videoGuard <= 1'b0;
		end else begin
			timing.drawArea <= (region == activeVideo) && (y < activeLines);
			timing.hSync <= !inHSync;
			timing.vSync <= !inVSync;
			timing.preamble <= (region == videoPreamble) ? 4'b0001 : 4'b0000;
			timing.videoGuard <= (region == videoGuard);
		end
	end

	assert property (@(posedge pixclk) disable iff (reset) x <= lastX && y <= lastY);

	// Guard band must stay clear of active pixels on every line
	assert property (@(posedge pixclk) disable iff (reset)
		!(timing.drawArea && timing.videoGuard));

endmodule

// File: source/tmdsChannelEncoder.sv
`timescale 1ns/1ns
/* One TMDS channel: transition minimising, DC balancing and control words.
   Two pipeline stages, so a symbol follows its inputs by two clocks. */
module tmdsChannelEncoder import videoPkg::*; (
	input logic pixclk,
	input logic reset,
	videoTimingIf.encoder timing,
	input colorComponent colour,
	input controlPair control,
	output tmdsSymbol symbol
);

	logic [3:0] colourOnes;
	logic useXnor;
	logic [8:0] tmWord;
	logic [8:0] qm;
	logic drawAreaD;
	controlPair controlD;
	disparityCount disparity;
	disparityCount balance;
	disparityCount qmWeight;
	disparityCount qmMiss;

	function automatic logic [3:0] onesCount(input logic [7:0] value);
		logic [3:0] total;
		total = '0;
		for (int i = 0; i < 8; i++) begin
			total = total + 4'(value[i]);
		end
		return total;
	endfunction

	////////////////////////////////////////////////////////////
	// Stage one

	// XNOR chaining when the colour is ones heavy
	always_comb begin
		colourOnes = onesCount(colour);
		useXnor = (colourOnes > 4'd4) || (colourOnes == 4'd4 && !colour[0]);
		tmWord[0] = colour[0];
		for (int i = 1; i < 8; i++) begin
			tmWord[i] = useXnor ? ~(tmWord[i-1] ^ colour[i]) : (tmWord[i-1] ^ colour[i]);
		end
		tmWord[8] = !useXnor;
	end

	always_ff @(posedge pixclk) begin
		qm <= tmWord;
	end

	always_ff @(posedge pixclk) begin
		if (reset) begin
			drawAreaD <= 1'b0;
			controlD <= 2'b00;
		end else begin
			drawAreaD <= timing.drawArea;
			controlD <= control;
		end
	end

	////////////////////////////////////////////////////////////
	// Stage two

	// Half of (ones - zeros) over the data bits
	assign balance = disparityCount'(int'(onesCount(qm[7:0])) - 4);
	assign qmWeight = qm[8] ? 4'sd1 : 4'sd0;
	assign qmMiss = qm[8] ? 4'sd0 : 4'sd1;

	always_ff @(posedge pixclk) begin
		if (reset) begin
			disparity <= '0;
			symbol <= controlSymbols[0];
		end else if (!drawAreaD) begin
			disparity <= '0;
			symbol <= controlSymbols[controlD];
		end else if (balance == 0 || disparity == 0) begin
			if (qm[8]) begin
				symbol <= {1'b0, 1'b1, qm[7:0]};
				disparity <= disparity + balance;
			end else begin
				symbol <= {1'b1, 1'b0, ~qm[7:0]};
				disparity <= disparity - balance;
			end
		end else if (balance[3] == disparity[3]) begin
			// Word leans the same way as the bias, send it inverted
			symbol <= {1'b1, qm[8], ~qm[7:0]};
			disparity <= disparity + qmWeight - balance;
		end else begin
			symbol <= {1'b0, qm[8], qm[7:0]};
			disparity <= disparity - qmMiss + balance;
		end
	end

	// Full DC bias is twice this value, so it stays even and within eight
	assert property (@(posedge pixclk) disable iff (reset) disparity >= -4 && disparity <= 4);

endmodule

// File: source/linkOutputStage.sv
`timescale 1ns/1ns
/* Inserts video guard-band symbols in line with the encoder pipeline
   and registers the three channel symbols for the link */
module linkOutputStage import videoPkg::*; (
	input logic pixclk,
	input logic reset,
	videoTimingIf.link timing,
	input tmdsSymbol encoded [channelCount],
	output tmdsSymbol tmdsRed,
	output tmdsSymbol tmdsGreen,
	output tmdsSymbol tmdsBlue
);

	// Matches the two encoder stages
	logic [1:0] guardDelay;

	always_ff @(posedge pixclk) begin
		if (reset) begin
			guardDelay <= 2'b00;
		end else begin
			guardDelay <= {guardDelay[0], timing.videoGuard};
		end
	end

	////////////////////////////////////////////////////////////
	// Output registers

	// Channel 2 is red, channel 1 green, channel 0 blue
	always_ff @(posedge pixclk) begin
		if (reset) begin
			tmdsRed <= controlSymbols[0];
			tmdsGreen <= controlSymbols[0];
			tmdsBlue <= controlSymbols[0];
		end else if (guardDelay[1]) begin
			tmdsRed <= guardSymbolOuter;
			tmdsGreen <= guardSymbolInner;
			tmdsBlue <= guardSymbolOuter;
		end else begin
			tmdsRed <= encoded[2];
			tmdsGreen <= encoded[1];
			tmdsBlue <= encoded[0];
		end
	end

	// Each guard band is exactly guardLength symbols long
	assert property (@(posedge pixclk) disable iff (reset)
		$rose(guardDelay[1]) |-> guardDelay[1] [*guardLength] ##1 !guardDelay[1]);

endmodule

// File: source/hdmiVideoTx.sv
`timescale 1ns/1ns
/* TMDS video transmitter top level, three 10-bit symbols per pixel clock.
   Colours are sampled on every edge where pixelRequest is high. */
module hdmiVideoTx import videoPkg::*; #(
	parameter int displayWidth = defaultWidth,
	parameter int displayHeight = defaultHeight,
	parameter int totalWidth = defaultTotalWidth,
	parameter int totalHeight = defaultTotalHeight,
	parameter int hFrontPorch = defaultHFrontPorch,
	parameter int hSyncLength = defaultHSyncLength,
	parameter int vFrontPorch = defaultVFrontPorch,
	parameter int vSyncLength = defaultVSyncLength
) (
	input logic pixclk,
	input logic reset,
	input colorComponent red,
	input colorComponent green,
	input colorComponent blue,
	output logic pixelRequest,
	output tmdsSymbol tmdsRed,
	output tmdsSymbol tmdsGreen,
	output tmdsSymbol tmdsBlue
);

	videoTimingIf timingBus();

	colorComponent channelColour [channelCount];
	controlPair channelControl [channelCount];
	tmdsSymbol encoded [channelCount];

	videoTiming #(
		.displayWidth(displayWidth),
		.displayHeight(displayHeight),
		.totalWidth(totalWidth),
		.totalHeight(totalHeight),
		.hFrontPorch(hFrontPorch),
		.hSyncLength(hSyncLength),
		.vFrontPorch(vFrontPorch),
		.vSyncLength(vSyncLength)
	) u_videoTiming (
		.pixclk(pixclk),
		.reset(reset),
		.timing(timingBus)
	);

	assign pixelRequest = timingBus.drawArea;

	////////////////////////////////////////////////////////////
	// Channel encoders

	// Syncs ride on blue, the preamble CTL bits on green and red
	assign channelColour[0] = blue;
	assign channelColour[1] = green;
	assign channelColour[2] = red;
	assign channelControl[0] = {timingBus.vSync, timingBus.hSync};
	assign channelControl[1] = timingBus.preamble[1:0];
	assign channelControl[2] = timingBus.preamble[3:2];

	for (genvar ch = 0; ch < channelCount; ch++) begin : g_channel
		tmdsChannelEncoder u_encoder (
			.pixclk(pixclk),
			.reset(reset),
			.timing(timingBus),
			.colour(channelColour[ch]),
			.control(channelControl[ch]),
			.symbol(encoded[ch])
		);
	end

	linkOutputStage u_linkOutputStage (
		.pixclk(pixclk),
		.reset(reset),
		.timing(timingBus),
		.encoded(encoded),
		.tmdsRed(tmdsRed),
		.tmdsGreen(tmdsGreen),
		.tmdsBlue(tmdsBlue)
	);

endmodule

// File: verif/clockGen.sv
`timescale 1ns/1ns
/* Pixel clock and synchronous reset for the testbench, reset released on a falling edge */
module clockGen #(
	parameter int periodNs = 100,
	parameter int resetCycles = 10
) (
	output logic pixclk,
	output logic reset
);

	localparam int halfPeriod = periodNs / 2;

	initial begin
		pixclk = 1'b0;
		forever #(halfPeriod) pixclk = ~pixclk;
	end

	// Reset covers resetCycles rising edges
	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge pixclk);
		@(negedge pixclk);
		reset = 1'b0;
	end

endmodule

// File: verif/hdmiVideoTxTb.sv
`timescale 1ns/1ns
/* Testbench for hdmiVideoTx on a small raster. Random colours go in on falling edges and a
   raster and TMDS model predicts every symbol three clocks later. */
module hdmiVideoTxTb import videoPkg::*; ();

	// Small raster keeps three frames short
	localparam int displayWidth = 16;
	localparam int displayHeight = 6;
	localparam int totalWidth = 48;
	localparam int totalHeight = 10;
	localparam int hFrontPorch = 4;
	localparam int hSyncLength = 8;
	localparam int vFrontPorch = 1;
	localparam int vSyncLength = 2;

	localparam int frameCycles = totalWidth * totalHeight;
	localparam int testFrames = 3;
	localparam int cycleLimit = testFrames * frameCycles + 100;
	// Flags to output symbols
	localparam int pipeDelay = 3;

	localparam tmdsSymbol guardOuter = 10'b1011001100;
	localparam tmdsSymbol guardInner = 10'b0100110011;

	logic pixclk;
	logic reset;
	colorComponent red;
	colorComponent green;
	colorComponent blue;
	logic pixelRequest;
	tmdsSymbol tmdsRed;
	tmdsSymbol tmdsGreen;
	tmdsSymbol tmdsBlue;

	// Model raster position and the flags it implies
	int modelX;
	int modelY;
	logic expDraw;
	logic expHSync;
	logic expVSync;
	logic [3:0] expPreamble;
	logic expGuard;
	int disparity [channelCount];

	tmdsSymbol redQueue [$];
	tmdsSymbol greenQueue [$];
	tmdsSymbol blueQueue [$];

	logic [31:0] rngState;
	int cycleCount = 0;

	clockGen #(
		.periodNs(100),
		.resetCycles(10)
	) u_clockGen (
		.pixclk(pixclk),
		.reset(reset)
	);

	hdmiVideoTx #(
		.displayWidth(displayWidth),
		.displayHeight(displayHeight),
		.totalWidth(totalWidth),
		.totalHeight(totalHeight),
		.hFrontPorch(hFrontPorch),
		.hSyncLength(hSyncLength),
		.vFrontPorch(vFrontPorch),
		.vSyncLength(vSyncLength)
	) u_hdmiVideoTx (
		.pixclk(pixclk),
		.reset(reset),
		.red(red),
		.green(green),
		.blue(blue),
		.pixelRequest(pixelRequest),
		.tmdsRed(tmdsRed),
		.tmdsGreen(tmdsGreen),
		.tmdsBlue(tmdsBlue)
	);

	////////////////////////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		logic [31:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic int countOnes(input logic [7:0] value);
		int total;
		total = 0;
		for (int i = 0; i < 8; i++) begin
			total += int'(value[i]);
		end
		return total;
	endfunction

	// DVI control words by {C1, C0}
	function automatic tmdsSymbol controlWord(input controlPair c);
		case (c)
			2'b00: return 10'b1101010100;
			2'b01: return 10'b0010101011;
			2'b10: return 10'b0101010100;
			default: return 10'b1010101011;
		endcase
	endfunction

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic checkSymbol(input string name, input tmdsSymbol actual,
		input tmdsSymbol expected);
		if (actual !== expected) begin
			failRun($sformatf("[FAIL] %s got 0x%h expected 0x%h (model x=%0d y=%0d)",
				name, actual, expected, modelX, modelY));
		end
	endtask

	task automatic checkRequest(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			failRun($sformatf("[FAIL] %s got 0x%h expected 0x%h (model x=%0d y=%0d)",
				name, actual, expected, modelX, modelY));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model

	// DVI 1.0 encoder with disparity kept in full bit units
	task automatic tmdsEncode(input int ch, input colorComponent d, output tmdsSymbol sym);
		logic [8:0] qm;
		logic xnorChain;
		int n1d;
		int n1q;
		int n0q;
		n1d = countOnes(d);
		xnorChain = (n1d > 4) || (n1d == 4 && d[0] == 1'b0);
		qm[0] = d[0];
		for (int i = 1; i < 8; i++) begin
			qm[i] = xnorChain ? (qm[i-1] ~^ d[i]) : (qm[i-1] ^ d[i]);
		end
		qm[8] = ~xnorChain;
		n1q = countOnes(qm[7:0]);
		n0q = 8 - n1q;
		if (disparity[ch] == 0 || n1q == n0q) begin
			sym = {~qm[8], qm[8], (qm[8] ? qm[7:0] : ~qm[7:0])};
			if (qm[8]) begin
				disparity[ch] += n1q - n0q;
			end else begin
				disparity[ch] += n0q - n1q;
			end
		end else if ((disparity[ch] > 0 && n1q > n0q) || (disparity[ch] < 0 && n0q > n1q)) begin
			sym = {1'b1, qm[8], ~qm[7:0]};
			disparity[ch] += 2 * int'(qm[8]) + n0q - n1q;
		end else begin
			sym = {1'b0, qm[8], qm[7:0]};
			disparity[ch] += n1q - n0q - (qm[8] ? 0 : 2);
		end
	endtask

	// Flags registered from the current position, then the position moves on
	task automatic advanceRaster();
		int pos;
		int vStart;
		int vEnd;
		int hStart;
		hStart = displayWidth + hFrontPorch;
		pos = modelY * totalWidth + modelX;
		vStart = (displayHeight + vFrontPorch - 1) * totalWidth + hStart;
		vEnd = (displayHeight + vFrontPorch + vSyncLength - 1) * totalWidth + hStart;
		expDraw = (modelX < displayWidth) && (modelY < displayHeight);
		expHSync = !(modelX >= hStart && modelX < hStart + hSyncLength);
		expVSync = !(pos >= vStart && pos < vEnd);
		expPreamble = (modelX >= totalWidth - guardLength - preambleLength
			&& modelX < totalWidth - guardLength) ? 4'b0001 : 4'b0000;
		expGuard = modelX >= totalWidth - guardLength;
		if (modelX == totalWidth - 1) begin
			modelX = 0;
			modelY = (modelY == totalHeight - 1) ? 0 : modelY + 1;
		end else begin
			modelX++;
		end
	endtask

	// Symbols for the present flags and colours that are due pipeDelay clocks later
	task automatic predictSymbols(input colorComponent r, input colorComponent g,
		input colorComponent b);
		tmdsSymbol sym [channelCount];
		colorComponent colours [channelCount];
		controlPair controls [channelCount];
		colours[0] = b;
		colours[1] = g;
		colours[2] = r;
		controls[0] = {expVSync, expHSync};
		controls[1] = expPreamble[1:0];
		controls[2] = expPreamble[3:2];
		for (int ch = 0; ch < channelCount; ch++) begin
			if (expDraw) begin
				tmdsEncode(ch, colours[ch], sym[ch]);
			end else begin
				disparity[ch] = 0;
				sym[ch] = controlWord(controls[ch]);
			end
		end
		if (expGuard) begin
			sym[2] = guardOuter;
			sym[1] = guardInner;
			sym[0] = guardOuter;
		end
		redQueue.push_back(sym[2]);
		greenQueue.push_back(sym[1]);
		blueQueue.push_back(sym[0]);
	endtask

	// Check outputs, then drive new colours and queue their prediction
	task automatic stepCycle();
		checkRequest("pixelRequest", pixelRequest, expDraw);
		checkSymbol("tmdsRed", tmdsRed, redQueue.pop_front());
		checkSymbol("tmdsGreen", tmdsGreen, greenQueue.pop_front());
		checkSymbol("tmdsBlue", tmdsBlue, blueQueue.pop_front());
		rngState = nextRandom(rngState);
		red = rngState[23:16];
		green = rngState[15:8];
		blue = rngState[7:0];
		predictSymbols(red, green, blue);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		red = '0;
		green = '0;
		blue = '0;
		rngState = 32'h764e;
		modelX = 0;
		modelY = 0;
		expDraw = 1'b0;
		expHSync = 1'b1;
		expVSync = 1'b1;
		expPreamble = 4'b0000;
		expGuard = 1'b0;
		for (int ch = 0; ch < channelCount; ch++) begin
			disparity[ch] = 0;
		end
		// Reset values still in the pipeline
		repeat (pipeDelay) begin
			redQueue.push_back(controlWord(2'b00));
			greenQueue.push_back(controlWord(2'b00));
			blueQueue.push_back(controlWord(2'b00));
		end
		@(negedge reset);
		stepCycle();
		for (int frame = 0; frame < testFrames; frame++) begin
			for (int i = 0; i < frameCycles; i++) begin
				@(negedge pixclk);
				advanceRaster();
				stepCycle();
			end
		end
		$display(">>> PASS");
		$finish;
	end

	always @(posedge pixclk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			failRun($sformatf("Timeout after %0d clock cycles, test sequence did not finish",
				cycleCount));
		end
	end

endmodule

// File: compile.f
source/videoPkg.sv
source/videoTimingIf.sv
source/videoTiming.sv
source/tmdsChannelEncoder.sv
source/linkOutputStage.sv
source/hdmiVideoTx.sv
verif/clockGen.sv
verif/hdmiVideoTxTb.sv

// File: Makefile
# Verilator build and run for the TMDS video transmitter testbench

VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = hdmiVideoTxTb
FILELIST = compile.f
OBJDIR = obj_dir
LOG = sim.log

SOURCES = $(shell cat $(FILELIST))
BINARY = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# The log decides the result, the simulator status is not trusted
run: compile
	./$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^>>> PASS$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
